/* project.f */
source/rv32_fetch_pkg.sv
source/fetch_stage.sv
source/imem_port.sv
source/branch_predictor.sv
source/fetch_hazard_unit.sv
source/fetch_subsystem.sv
verification/fetch_clock_gen.sv
verification/fetch_tb.sv

/* Bender.yml */
package:
  name: rv32_fetch

sources:
  - source/rv32_fetch_pkg.sv
  - source/fetch_stage.sv
  - source/imem_port.sv
  - source/branch_predictor.sv
  - source/fetch_hazard_unit.sv
  - source/fetch_subsystem.sv
  - target: test
    files:
      - verification/fetch_clock_gen.sv
      - verification/fetch_tb.sv

/* verification/fetch_tb.sv */
// Testbench for the fetch subsystem
// Plays instruction memory and execute, applies a table of redirects,
// traps, BTB updates and stalls, and checks every entry sent to execute
`timescale 1ns/1ps

module fetch_tb;
    import rv32_fetch_pkg::*;

    localparam addr_t RESET_PC = 32'h80000000;
    localparam word_t PATTERN  = 32'h5a5a0000;
    localparam int    NROWS    = 10;
    localparam int    LIMIT    = NROWS * 40;
    localparam int    EV_NONE = 0, EV_REDIR = 1, EV_TRAP = 2, EV_BP_SET = 3, EV_BP_CLR = 4;

    logic  CLK, nRST;
    logic  imem_req, imem_ack, imem_error;
    addr_t imem_addr;
    word_t imem_rdata;
    logic  redirect, trap, bp_update, bp_taken, out_stall;
    addr_t redirect_target, trap_pc, bp_pc, bp_target;
    logic  ex_valid, ex_prediction, ex_mal_insn, ex_fault_insn;
    word_t ex_instr;
    addr_t ex_pc, ex_pc4, ex_fault_addr;

    // Row: entries to wait, event, address, second address, stall cycles
    int    row_gap   [NROWS] = '{3, 2, 2, 0, 4, 1, 1, 4, 3, 3};
    int    row_kind  [NROWS] = '{EV_REDIR, EV_TRAP, EV_BP_SET, EV_REDIR, EV_NONE,
                                 EV_BP_CLR, EV_REDIR, EV_REDIR, EV_REDIR, EV_NONE};
    addr_t row_addr  [NROWS] = '{32'h80000100, 32'h80000200, 32'h80000408, 32'h80000400, 0,
                                 32'h80000408, 32'h80000400, 32'h80000502, 32'h80000040, 0};
    addr_t row_addr2 [NROWS] = '{0, 32'h80000300, 32'h80000600, 0, 0, 0, 0, 0, 0, 0};
    int    row_stall [NROWS] = '{0, 0, 0, 0, 6, 0, 0, 5, 0, 0};

    addr_t err_table [3] = '{32'h80000008, 32'h80000044, 32'h80000604};

    logic [31:0] lfsr_state = 32'hcf10;
    logic [1:0]  mem_delay;
    int          cycles, checks, errors, entry_cnt;

    // Reference model state
    addr_t exp_pc;
    logic  bm_valid [8];
    addr_t bm_tag [8];
    addr_t bm_tgt [8];
    logic  stall_prev, flush_prev;
    logic  valid_s, pred_s, mal_s, fault_s;
    word_t instr_s;
    addr_t pc_s, pc4_s, faddr_s;

    fetch_clock_gen fetch_clock_gen_i (.CLK, .nRST);

    fetch_subsystem #(.RESET_PC(RESET_PC), .BUS_SWAP(1'b0), .BTB_ENTRIES(8)) fetch_subsystem_i (
        .CLK, .nRST,
        .imem_req, .imem_addr, .imem_ack, .imem_error, .imem_rdata,
        .redirect, .redirect_target, .trap, .trap_pc,
        .bp_update, .bp_taken, .bp_pc, .bp_target, .out_stall,
        .ex_valid, .ex_prediction, .ex_mal_insn, .ex_fault_insn,
        .ex_instr, .ex_pc, .ex_pc4, .ex_fault_addr
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [1:0] take_bits(input int n);
        logic [1:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic logic in_err_table(input addr_t a);
        in_err_table = 1'b0;
        foreach (err_table[i]) if (err_table[i] == a) in_err_table = 1'b1;
    endfunction

    function automatic logic btb_hit(input addr_t a);
        btb_hit = bm_valid[a[4:2]] && (bm_tag[a[4:2]][31:5] == a[31:5]);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // Memory model, acks after 0 to 3 idle cycles
    always @(posedge CLK) begin
        if (!nRST) begin
            imem_ack <= 1'b0;
        end else if (imem_ack) begin
            if (!imem_req) imem_ack <= 1'b0;  // Phase 4
        end else if (imem_req) begin
            if (mem_delay == 0) begin
                imem_ack   <= 1'b1;
                imem_rdata <= imem_addr ^ PATTERN;
                imem_error <= in_err_table(imem_addr);
                mem_delay  <= take_bits(2);
            end else begin
                mem_delay <= mem_delay - 2'd1;
            end
        end
    end

    // Monitor, samples mid-cycle when everything is settled
    always @(negedge CLK) begin
        if (nRST) begin
            if (imem_req && imem_addr[1:0] != 2'b00) begin
                errors++;
                $display("Bus request issued for misaligned address %h", imem_addr);
            end
            if (stall_prev && !flush_prev) begin  // Register must hold
                check_val("ex_valid (stall)", ex_valid, valid_s);
                check_val("ex_instr (stall)", ex_instr, instr_s);
                check_val("ex_pc (stall)", ex_pc, pc_s);
                check_val("ex_pc4 (stall)", ex_pc4, pc4_s);
                check_val("ex_prediction (stall)", ex_prediction, pred_s);
                check_val("ex_mal_insn (stall)", ex_mal_insn, mal_s);
                check_val("ex_fault_insn (stall)", ex_fault_insn, fault_s);
                check_val("ex_fault_addr (stall)", ex_fault_addr, faddr_s);
            end else if (ex_valid) begin  // Freshly loaded entry
                entry_cnt++;
                check_val("ex_pc", ex_pc, exp_pc);
                check_val("ex_pc4", ex_pc4, exp_pc + 32'd4);
                check_val("ex_prediction", ex_prediction, btb_hit(exp_pc));
                check_val("ex_fault_addr", ex_fault_addr, exp_pc);
                if (exp_pc[1:0] != 2'b00) begin
                    check_val("ex_mal_insn", ex_mal_insn, 1'b1);
                    check_val("ex_fault_insn", ex_fault_insn, 1'b0);
                    check_val("ex_instr", ex_instr, NOP_INSTR);
                end else begin
                    check_val("ex_mal_insn", ex_mal_insn, 1'b0);
                    check_val("ex_fault_insn", ex_fault_insn, in_err_table(exp_pc));
                    check_val("ex_instr", ex_instr,
                              in_err_table(exp_pc) ? NOP_INSTR : exp_pc ^ PATTERN);
                end
                exp_pc = btb_hit(exp_pc) ? bm_tgt[exp_pc[4:2]] : exp_pc + 32'd4;
            end
        end
        stall_prev = out_stall;
        flush_prev = redirect | trap;
        {valid_s, instr_s, pc_s, pc4_s} = {ex_valid, ex_instr, ex_pc, ex_pc4};
        {pred_s, mal_s, fault_s} = {ex_prediction, ex_mal_insn, ex_fault_insn};
        faddr_s = ex_fault_addr;
    end

    // Run limit
    always @(posedge CLK) begin
        cycles++;
        if (cycles > LIMIT + 16) begin
            $display("Timeout after %0d cycles, entries stopped arriving", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int goal;
        {redirect, trap, bp_update, bp_taken, out_stall} = '0;
        {redirect_target, trap_pc, bp_pc, bp_target} = '0;
        {imem_ack, imem_error, imem_rdata} = '0;
        {cycles, checks, errors, entry_cnt} = '0;
        {stall_prev, flush_prev} = '0;
        exp_pc = RESET_PC;
        foreach (bm_valid[i]) bm_valid[i] = 1'b0;
        mem_delay = take_bits(2);
        @(posedge nRST);
        check_val("imem_req", imem_req, 1'b0);
        check_val("ex_valid", ex_valid, 1'b0);
        for (int r = 0; r < NROWS; r++) begin
            goal = entry_cnt + row_gap[r];
            @(posedge CLK);
            while (entry_cnt < goal) @(posedge CLK);
            if (row_stall[r] > 0) begin
                out_stall <= 1'b1;
                repeat (row_stall[r] - 1) @(posedge CLK);
            end
            case (row_kind[r])  // Event lands in the last stall cycle
                EV_REDIR: begin
                    redirect        <= 1'b1;
                    redirect_target <= row_addr[r];
                end
                EV_TRAP: begin
                    trap            <= 1'b1;
                    trap_pc         <= row_addr[r];
                    redirect        <= 1'b1;
                    redirect_target <= row_addr2[r];
                end
                EV_BP_SET, EV_BP_CLR: begin
                    bp_update <= 1'b1;
                    bp_taken  <= (row_kind[r] == EV_BP_SET);
                    bp_pc     <= row_addr[r];
                    bp_target <= row_addr2[r];
                end
                default: ;
            endcase
            @(posedge CLK);
            {redirect, trap, bp_update, bp_taken, out_stall} <= '0;
            case (row_kind[r])  // Model follows the DUT from this edge on
                EV_REDIR:  exp_pc = row_addr[r];
                EV_TRAP:   exp_pc = row_addr[r];
                EV_BP_SET: begin
                    bm_valid[row_addr[r][4:2]] = 1'b1;
                    bm_tag[row_addr[r][4:2]]   = row_addr[r];
                    bm_tgt[row_addr[r][4:2]]   = row_addr2[r];
                end
                EV_BP_CLR: if (btb_hit(row_addr[r])) bm_valid[row_addr[r][4:2]] = 1'b0;
                default: ;
            endcase
            $display("Test %0d done, %0d entries so far, %0d errors", r, entry_cnt, errors);
        end
        goal = entry_cnt + 3;
        while (entry_cnt < goal) @(posedge CLK);
        $display("Checks %0d, entries %0d, errors %0d", checks, entry_cnt, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verification/fetch_clock_gen.sv */
// Testbench clock and reset source
// 100 ns clock, reset held low for the first 16 cycles
`timescale 1ns/1ps

module fetch_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK  = 1'b0;
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;  // Released on an edge, like the other inputs
    end

    always #50 CLK = ~CLK;

endmodule

/* source/fetch_subsystem.sv */
// Instruction fetch subsystem top level
// Connects fetch stage, bus port, BTB and hazard unit to the outside
`timescale 1ns/1ps

module fetch_subsystem #(
    parameter rv32_fetch_pkg::addr_t RESET_PC    = 32'h80000000,
    parameter bit                    BUS_SWAP    = 1'b0,
    parameter int                    BTB_ENTRIES = 8
) (
    input  logic                  CLK,
    input  logic                  nRST,
    // Instruction bus
    output logic                  imem_req,
    output rv32_fetch_pkg::addr_t imem_addr,
    input  logic                  imem_ack,
    input  logic                  imem_error,
    input  rv32_fetch_pkg::word_t imem_rdata,
    // From execute
    input  logic                  redirect,
    input  rv32_fetch_pkg::addr_t redirect_target,
    input  logic                  trap,
    input  rv32_fetch_pkg::addr_t trap_pc,
    input  logic                  bp_update,
    input  logic                  bp_taken,
    input  rv32_fetch_pkg::addr_t bp_pc,
    input  rv32_fetch_pkg::addr_t bp_target,
    input  logic                  out_stall,
    // To execute
    output logic                  ex_valid,
    output logic                  ex_prediction,
    output logic                  ex_mal_insn,
    output logic                  ex_fault_insn,
    output rv32_fetch_pkg::word_t ex_instr,
    output rv32_fetch_pkg::addr_t ex_pc,
    output rv32_fetch_pkg::addr_t ex_pc4,
    output rv32_fetch_pkg::addr_t ex_fault_addr
);
    import rv32_fetch_pkg::*;

    addr_t pc, fetch_addr, predict_target;
    word_t fetch_rdata;
    logic  fetch_ren, fetch_done, fetch_err, bus_busy, mal_fetch;
    logic  predict_taken;
    logic  pc_en, fex_stall, fex_flush, drop_resp;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_i (
        .CLK, .nRST,
        .pc_en, .fex_stall, .fex_flush, .drop_resp,
        .trap, .redirect, .trap_pc, .redirect_target,
        .predict_taken, .predict_target,
        .fetch_done, .fetch_err, .fetch_rdata, .fetch_addr, .fetch_ren,
        .pc, .mal_fetch,
        .ex_valid, .ex_instr, .ex_pc, .ex_pc4, .ex_prediction,
        .ex_mal_insn, .ex_fault_insn, .ex_fault_addr
    );

    imem_port #(.BUS_SWAP(BUS_SWAP)) imem_port_i (
        .CLK, .nRST,
        .fetch_ren, .fetch_addr, .fetch_done, .fetch_err, .bus_busy, .fetch_rdata,
        .imem_req, .imem_addr, .imem_ack, .imem_error, .imem_rdata
    );

    branch_predictor #(.BTB_ENTRIES(BTB_ENTRIES)) branch_predictor_i (
        .CLK, .nRST,
        .pc, .predict_taken, .predict_target,
        .bp_update, .bp_taken, .bp_pc, .bp_target
    );

    fetch_hazard_unit fetch_hazard_unit_i (
        .CLK, .nRST,
        .fetch_done, .mal_fetch, .bus_busy, .out_stall, .redirect, .trap,
        .pc_en, .fex_stall, .fex_flush, .drop_resp
    );

endmodule

/* source/fetch_hazard_unit.sv */
// Fetch hazard unit
// Decides PC enable, register stall and flush, and tracks responses
// that must be thrown away after a redirect
`timescale 1ns/1ps

module fetch_hazard_unit (
    input  logic CLK,
    input  logic nRST,
    input  logic fetch_done,
    input  logic mal_fetch,
    input  logic bus_busy,
    input  logic out_stall,
    input  logic redirect,
    input  logic trap,
    output logic pc_en,
    output logic fex_stall,
    output logic fex_flush,
    output logic drop_resp
);

    logic flush;
    logic drop_q;  // Old-path word still on its way

    assign flush = redirect | trap;

    // Set when a redirect meets a busy bus, cleared when that word arrives
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            drop_q <= 1'b0;
        end else if (flush && bus_busy) begin
            drop_q <= 1'b1;
        end else if (fetch_done) begin
            drop_q <= 1'b0;
        end
    end

    assign drop_resp = drop_q;
    assign fex_flush = flush;
    assign fex_stall = out_stall & ~flush;  // Flush wins over back-pressure

    // Advance on a finished entry, or jump on redirect
    assign pc_en = flush | ((fetch_done | mal_fetch) & ~out_stall & ~drop_q);

    // A pending drop always has a transfer or held word behind it
    a_drop_needs_busy : assert property (
        @(posedge CLK) disable iff (!nRST) drop_resp |-> bus_busy
    ) else $error("drop_resp set with the instruction bus idle");

endmodule

/* source/branch_predictor.sv */
// Branch target buffer
// Direct mapped, looked up combinationally on the current PC
// and written by execute when a branch resolves
`timescale 1ns/1ps

module branch_predictor #(
    parameter int BTB_ENTRIES = 8
) (
    input  logic                  CLK,
    input  logic                  nRST,
    // Lookup
    input  rv32_fetch_pkg::addr_t pc,
    output logic                  predict_taken,
    output rv32_fetch_pkg::addr_t predict_target,
    // Update from execute
    input  logic                  bp_update,
    input  logic                  bp_taken,
    input  rv32_fetch_pkg::addr_t bp_pc,
    input  rv32_fetch_pkg::addr_t bp_target
);
    import rv32_fetch_pkg::*;

    localparam int TAG_W = 27;  // pc[31:5]

    // Index width is fixed by the package type
    if (BTB_ENTRIES != (1 << $bits(btb_idx_t))) begin : g_size_check
        $error("BTB_ENTRIES does not match the btb_idx_t width");
    end

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_mem [BTB_ENTRIES];
    addr_t                  target_mem [BTB_ENTRIES];

    btb_idx_t         rd_idx, wr_idx;
    logic [TAG_W-1:0] rd_tag, wr_tag;
    logic             upd_match;

    assign rd_idx = pc[4:2];
    assign rd_tag = pc[31:5];
    assign wr_idx = bp_pc[4:2];
    assign wr_tag = bp_pc[31:5];

    // Hit means predict taken
    assign predict_taken  = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign predict_target = target_mem[rd_idx];

    // Only drop the entry if it belongs to this branch
    assign upd_match = valid_q[wr_idx] && (tag_mem[wr_idx] == wr_tag);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (bp_update) begin
            if (bp_taken) begin
                valid_q[wr_idx] <= 1'b1;
            end else if (upd_match) begin
                valid_q[wr_idx] <= 1'b0;  // Not taken, fall back to pc+4
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (bp_update && bp_taken) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= bp_target;
        end
    end

endmodule

/* source/imem_port.sv */
// Instruction bus master
// Runs the four-phase req/ack handshake, captures the word and bus error,
// and holds the word until the fetch stage takes it
`timescale 1ns/1ps

module imem_port #(
    parameter bit BUS_SWAP = 1'b0
) (
    input  logic                  CLK,
    input  logic                  nRST,
    // Fetch stage side
    input  logic                  fetch_ren,
    input  rv32_fetch_pkg::addr_t fetch_addr,
    output logic                  fetch_done,
    output logic                  fetch_err,
    output logic                  bus_busy,
    output rv32_fetch_pkg::word_t fetch_rdata,
    // External bus
    output logic                  imem_req,
    output rv32_fetch_pkg::addr_t imem_addr,
    input  logic                  imem_ack,
    input  logic                  imem_error,
    input  rv32_fetch_pkg::word_t imem_rdata
);
    import rv32_fetch_pkg::*;

    bus_state_t state;
    logic       resp_valid;  // Captured word not yet taken
    addr_t      addr_q;
    word_t      rdata_in;

    generate
        if (BUS_SWAP) begin : g_swap
            // Reverse byte lanes
            assign rdata_in = {imem_rdata[7:0], imem_rdata[15:8],
                               imem_rdata[23:16], imem_rdata[31:24]};
        end else begin : g_no_swap
            assign rdata_in = imem_rdata;
        end
    endgenerate

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
        end else begin
            case (state)
                IDLE:         if (fetch_ren && !resp_valid) state <= REQ;
                REQ:          if (imem_ack) state <= WAIT_ACK_LOW;
                WAIT_ACK_LOW: if (!imem_ack) state <= IDLE;  // Phase 4 done
                default:      state <= IDLE;
            endcase
            if (state == REQ && imem_ack) begin
                resp_valid <= 1'b1;
            end else if (fetch_done) begin
                resp_valid <= 1'b0;
            end
        end
    end

    // Address held for the whole transfer, data sampled on first ack
    always_ff @(posedge CLK) begin
        if (state == IDLE && fetch_ren && !resp_valid) addr_q <= fetch_addr;
        if (state == REQ && imem_ack) begin
            fetch_rdata <= rdata_in;
            fetch_err   <= imem_error;
        end
    end

    assign imem_req   = (state == REQ);
    assign imem_addr  = addr_q;
    assign fetch_done = resp_valid & fetch_ren;  // Held back while stalled
    assign bus_busy   = (state == REQ) | resp_valid;  // A word is still owed

    a_addr_stable : assert property (
        @(posedge CLK) disable iff (!nRST) imem_req |=> !imem_req || $stable(imem_addr)
    ) else $error("imem_addr changed during a transfer");

endmodule

/* source/fetch_stage.sv */
// Instruction fetch stage
// Holds the PC, picks the next PC by priority and loads the fetch/execute
// register, squashing faulted or misaligned entries to a NOP
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv32_fetch_pkg::addr_t RESET_PC = 32'h80000000
) (
    input  logic                  CLK,
    input  logic                  nRST,
    // Hazard unit
    input  logic                  pc_en,
    input  logic                  fex_stall,
    input  logic                  fex_flush,
    input  logic                  drop_resp,
    // Redirects from execute
    input  logic                  trap,
    input  logic                  redirect,
    input  rv32_fetch_pkg::addr_t trap_pc,
    input  rv32_fetch_pkg::addr_t redirect_target,
    // Branch predictor
    input  logic                  predict_taken,
    input  rv32_fetch_pkg::addr_t predict_target,
    // Instruction bus port
    input  logic                  fetch_done,
    input  logic                  fetch_err,
    input  rv32_fetch_pkg::word_t fetch_rdata,
    output rv32_fetch_pkg::addr_t fetch_addr,
    output logic                  fetch_ren,
    output rv32_fetch_pkg::addr_t pc,
    output logic                  mal_fetch,
    // Fetch/execute register
    output logic                  ex_valid,
    output rv32_fetch_pkg::word_t ex_instr,
    output rv32_fetch_pkg::addr_t ex_pc,
    output rv32_fetch_pkg::addr_t ex_pc4,
    output logic                  ex_prediction,
    output logic                  ex_mal_insn,
    output logic                  ex_fault_insn,
    output rv32_fetch_pkg::addr_t ex_fault_addr
);
    import rv32_fetch_pkg::*;

    addr_t pc4, npc;
    logic  fault_insn;
    logic  entry_done;  // An entry is ready for the register this cycle
    logic  ex_load;

    assign pc4 = pc + 32'd4;

    // Trap beats redirect beats a BTB hit beats sequential
    assign npc = trap          ? trap_pc :
                 redirect      ? redirect_target :
                 predict_taken ? predict_target :
                 pc4;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= npc;
        end
    end

    assign mal_fetch  = (pc[1:0] != 2'b00);
    assign fetch_addr = pc;
    // Misaligned pc never requests, but a stale word still has to drain
    assign fetch_ren  = (~mal_fetch | drop_resp) & ~fex_stall & ~fex_flush;

    assign fault_insn = fetch_done & fetch_err;  // Bus error on this word
    assign entry_done = (fetch_done | mal_fetch) & ~drop_resp;
    assign ex_load    = entry_done & ~fex_stall & ~fex_flush;

    // Valid bit, bubble when nothing completes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
        end else if (fex_flush) begin
            ex_valid <= 1'b0;  // Kill whatever was fetched down the old path
        end else if (!fex_stall) begin
            ex_valid <= entry_done;
        end
    end

    // Payload of the fetch/execute register
    always_ff @(posedge CLK) begin
        if (ex_load) begin
            ex_instr      <= (mal_fetch | fault_insn) ? NOP_INSTR : fetch_rdata;
            ex_pc         <= pc;
            ex_pc4        <= pc4;
            ex_prediction <= predict_taken;
            ex_mal_insn   <= mal_fetch;
            ex_fault_insn <= fault_insn;
            ex_fault_addr <= pc;  // Kept for the trap handler
        end
    end

    // Nothing from the old path may reach execute right after a flush
    a_no_valid_after_flush : assert property (
        @(posedge CLK) disable iff (!nRST) fex_flush |=> !ex_valid
    ) else $error("ex_valid set in the cycle after a flush");

endmodule

/* source/rv32_fetch_pkg.sv */
// RV32 fetch subsystem shared definitions
// Word and address types, BTB index and instruction bus FSM states
package rv32_fetch_pkg;

    // Data carried on the instruction bus
    typedef logic [31:0] word_t;

    // Byte address, also used for the PC and branch targets
    typedef logic [31:0] addr_t;

    // BTB index taken from pc[4:2]
    // 8 entries, one per word slot in a 32-byte window
    typedef logic [2:0] btb_idx_t;

    // States of the four-phase req/ack transfer
    typedef enum logic [1:0] {
        IDLE,         // No transfer, free to latch an address
        REQ,          // req high, waiting for ack
        WAIT_ACK_LOW  // Word captured, waiting for ack to drop
    } bus_state_t;

    // addi x0, x0, 0
    // Sent to execute in place of a faulted or misaligned fetch
    localparam word_t NOP_INSTR = 32'h00000013;

endpackage
